//--- common/video_pkg.sv
package video_pkg;

    // one 8-bit color channel
    typedef logic [7:0] color_t;

    // one 10-bit TMDS symbol as sent on a lane
    typedef logic [9:0] tmds_word_t;

    // raster counter, covers the 800 by 525 total raster
    typedef logic [9:0] coord_t;

    // running DC disparity of one lane, two's complement
    typedef logic signed [4:0] disparity_t;

    // control period symbols, suffix is {c1, c0}
    localparam tmds_word_t tmds_ctrl_00 = 10'b1101010100;
    localparam tmds_word_t tmds_ctrl_01 = 10'b0010101011;
    localparam tmds_word_t tmds_ctrl_10 = 10'b0101010100;
    localparam tmds_word_t tmds_ctrl_11 = 10'b1010101011;

endpackage

//--- design/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic              clk_pixel,
    input  logic              reset,
    output video_pkg::coord_t x,
    output video_pkg::coord_t y,
    output logic              hsync,
    output logic              vsync,
    output logic              blank
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // window edges in counter units
    localparam video_pkg::coord_t h_last       = video_pkg::coord_t'(h_total - 1);
    localparam video_pkg::coord_t v_last       = video_pkg::coord_t'(v_total - 1);
    localparam video_pkg::coord_t h_active_end = video_pkg::coord_t'(h_active);
    localparam video_pkg::coord_t v_active_end = video_pkg::coord_t'(v_active);
    localparam video_pkg::coord_t h_sync_start = video_pkg::coord_t'(h_active + h_front);
    localparam video_pkg::coord_t h_sync_end   = video_pkg::coord_t'(h_active + h_front + h_sync);
    localparam video_pkg::coord_t v_sync_start = video_pkg::coord_t'(v_active + v_front);
    localparam video_pkg::coord_t v_sync_end   = video_pkg::coord_t'(v_active + v_front + v_sync);

    video_pkg::coord_t x_next;
    video_pkg::coord_t y_next;

    // next raster position
    always_comb begin
        x_next = x + video_pkg::coord_t'(1);
        y_next = y;
        if (x == h_last) begin
            x_next = '0;
            if (y == v_last) begin
                y_next = '0;
            end else begin
                y_next = y + video_pkg::coord_t'(1);
            end
        end
    end

    // windows decoded from the next position so they line up with x and y
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            x     <= '0;
            y     <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            blank <= 1'b0;
        end else begin
            x     <= x_next;
            y     <= y_next;
            hsync <= (x_next >= h_sync_start) && (x_next < h_sync_end);
            vsync <= (y_next >= v_sync_start) && (y_next < v_sync_end);
            blank <= (x_next >= h_active_end) || (y_next >= v_active_end);
        end
    end

    // syncs only ever inside the blanking interval
    a_hsync_blanked: assert property (
        @(posedge clk_pixel) disable iff (reset)
        hsync |-> (blank && (x >= h_active_end))
    );

    a_vsync_blanked: assert property (
        @(posedge clk_pixel) disable iff (reset)
        vsync |-> (blank && (y >= v_active_end))
    );

endmodule

//--- design/test_pattern.sv
`timescale 1ns/100ps

module test_pattern #(
    parameter int h_active = 640
) (
    input  logic              clk_pixel,
    input  logic              reset,
    input  logic              test_picture,
    input  video_pkg::coord_t x,
    input  video_pkg::coord_t y,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              blank,
    output video_pkg::color_t red,
    output video_pkg::color_t green,
    output video_pkg::color_t blue,
    output logic              pix_hsync,
    output logic              pix_vsync,
    output logic              pix_blank
);

    // eight bars across the active width
    localparam int bar_width = h_active / 8;

    logic [2:0]        bar;
    video_pkg::coord_t diag;

    always_comb begin
        bar  = 3'(x / video_pkg::coord_t'(bar_width));
        diag = x + y;
    end

    // color for the current position
    always_ff @(posedge clk_pixel) begin
        if (test_picture) begin
            red   <= {8{bar[0]}};
            green <= {8{bar[1]}};
            blue  <= {8{bar[2]}};
        end else begin
            red   <= x[7:0];
            green <= y[7:0];
            blue  <= diag[7:0];
        end
    end

    // sync and blank follow the color by one cycle
    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            pix_hsync <= 1'b0;
            pix_vsync <= 1'b0;
            pix_blank <= 1'b1;
        end else begin
            pix_hsync <= hsync;
            pix_vsync <= vsync;
            pix_blank <= blank;
        end
    end

endmodule

//--- tmds/tmds_encoder.sv
`timescale 1ns/100ps

module tmds_encoder (
    input  logic                  clk_pixel,
    input  logic                  reset,
    input  video_pkg::color_t     data,
    input  logic                  c0,
    input  logic                  c1,
    input  logic                  blank,
    output video_pkg::tmds_word_t symbol
);

    // stage 1, transition minimizing
    logic [3:0] data_ones;
    logic       use_xnor;
    logic [8:0] q_m;
    logic [3:0] q_m_ones;

    logic [8:0] q_m_q;
    logic [3:0] ones_q;
    logic       blank_q;
    logic       c0_q;
    logic       c1_q;

    // stage 2, DC balance
    video_pkg::disparity_t disparity;
    video_pkg::disparity_t disparity_next;
    video_pkg::disparity_t balance;
    video_pkg::tmds_word_t data_symbol;

    always_comb begin
        data_ones = '0;
        for (int i = 0; i < 8; i++) begin
            data_ones = data_ones + 4'(data[i]);
        end
        use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);

        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        // bit 8 flags the XOR form
        q_m[8] = ~use_xnor;

        q_m_ones = '0;
        for (int i = 0; i < 8; i++) begin
            q_m_ones = q_m_ones + 4'(q_m[i]);
        end
    end

    always_ff @(posedge clk_pixel) begin
        q_m_q  <= q_m;
        ones_q <= q_m_ones;
    end

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            blank_q <= 1'b1;
            c0_q    <= 1'b0;
            c1_q    <= 1'b0;
        end else begin
            blank_q <= blank;
            c0_q    <= c0;
            c1_q    <= c1;
        end
    end

    always_comb begin
        // ones minus zeros of the low byte
        balance = video_pkg::disparity_t'({ones_q, 1'b0}) - video_pkg::disparity_t'(8);

        data_symbol[8] = q_m_q[8];
        if ((disparity == 0) || (balance == 0)) begin
            data_symbol[9]   = ~q_m_q[8];
            data_symbol[7:0] = q_m_q[8] ? q_m_q[7:0] : ~q_m_q[7:0];
            disparity_next   = q_m_q[8] ? disparity + balance : disparity - balance;
        end else if (((disparity > 0) && (balance > 0)) ||
                     ((disparity < 0) && (balance < 0))) begin
            // invert to pull disparity back toward zero
            data_symbol[9]   = 1'b1;
            data_symbol[7:0] = ~q_m_q[7:0];
            disparity_next   = disparity - balance +
                               (q_m_q[8] ? video_pkg::disparity_t'(2) : video_pkg::disparity_t'(0));
        end else begin
            data_symbol[9]   = 1'b0;
            data_symbol[7:0] = q_m_q[7:0];
            disparity_next   = disparity + balance -
                               (q_m_q[8] ? video_pkg::disparity_t'(0) : video_pkg::disparity_t'(2));
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (reset) begin
            symbol    <= video_pkg::tmds_ctrl_00;
            disparity <= '0;
        end else if (blank_q) begin
            disparity <= '0;
            case ({c1_q, c0_q})
                2'b00:   symbol <= video_pkg::tmds_ctrl_00;
                2'b01:   symbol <= video_pkg::tmds_ctrl_01;
                2'b10:   symbol <= video_pkg::tmds_ctrl_10;
                default: symbol <= video_pkg::tmds_ctrl_11;
            endcase
        end else begin
            symbol    <= data_symbol;
            disparity <= disparity_next;
        end
    end

    // balance rule keeps the lane close to DC neutral
    a_disparity_bound: assert property (
        @(posedge clk_pixel) disable iff (reset)
        !blank_q |=> ((disparity >= -10) && (disparity <= 10))
    );

endmodule

//--- tmds/dvi_transmitter.sv
`timescale 1ns/100ps

module dvi_transmitter (
    input  logic                  clk_pixel,
    input  logic                  reset,
    input  video_pkg::color_t     red,
    input  video_pkg::color_t     green,
    input  video_pkg::color_t     blue,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  blank,
    output video_pkg::tmds_word_t tmds_red,
    output video_pkg::tmds_word_t tmds_green,
    output video_pkg::tmds_word_t tmds_blue
);

    // syncs ride on the blue lane during blanking
    tmds_encoder blue_lane (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (blue),
        .c0        (hsync),
        .c1        (vsync),
        .blank     (blank),
        .symbol    (tmds_blue)
    );

    tmds_encoder green_lane (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (green),
        .c0        (1'b0),
        .c1        (1'b0),
        .blank     (blank),
        .symbol    (tmds_green)
    );

    tmds_encoder red_lane (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .data      (red),
        .c0        (1'b0),
        .c1        (1'b0),
        .blank     (blank),
        .symbol    (tmds_red)
    );

endmodule

//--- design/vga_dvi_top.sv
`timescale 1ns/100ps

module vga_dvi_top #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic                  clk_pixel,
    input  logic                  reset,
    input  logic                  test_picture,
    output video_pkg::tmds_word_t tmds_red,
    output video_pkg::tmds_word_t tmds_green,
    output video_pkg::tmds_word_t tmds_blue
);

    // raster position and windows
    video_pkg::coord_t x;
    video_pkg::coord_t y;
    logic              hsync;
    logic              vsync;
    logic              blank;

    // pixel stream, one cycle behind the raster
    video_pkg::color_t red;
    video_pkg::color_t green;
    video_pkg::color_t blue;
    logic              pix_hsync;
    logic              pix_vsync;
    logic              pix_blank;

    video_timing #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) timing (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .x         (x),
        .y         (y),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank)
    );

    test_pattern #(
        .h_active (h_active)
    ) pattern (
        .clk_pixel    (clk_pixel),
        .reset        (reset),
        .test_picture (test_picture),
        .x            (x),
        .y            (y),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank        (blank),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .pix_hsync    (pix_hsync),
        .pix_vsync    (pix_vsync),
        .pix_blank    (pix_blank)
    );

    dvi_transmitter transmitter (
        .clk_pixel  (clk_pixel),
        .reset      (reset),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hsync      (pix_hsync),
        .vsync      (pix_vsync),
        .blank      (pix_blank),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

endmodule

//--- sim/tmds_model.svh
`ifndef TMDS_MODEL_SVH
`define TMDS_MODEL_SVH

// number of ones in the low width bits
function automatic int count_ones(logic [9:0] w, int width);
    int n;
    n = 0;
    for (int i = 0; i < width; i++) begin
        n = n + w[i];
    end
    return n;
endfunction

// DC contribution of one symbol as ones minus zeros
function automatic int symbol_balance(video_pkg::tmds_word_t s);
    return 2 * count_ones(s, 10) - 10;
endfunction

// DVI 8b/10b data encoding for a given running disparity
function automatic video_pkg::tmds_word_t encode_pixel(video_pkg::color_t d, int disp);
    logic [8:0] q_m;
    logic       xnor_form;
    int         n1;
    int         bal;
    n1 = count_ones({2'b00, d}, 8);
    xnor_form = (n1 > 4) || ((n1 == 4) && (d[0] == 1'b0));
    q_m[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        q_m[i] = xnor_form ? (q_m[i-1] ~^ d[i]) : (q_m[i-1] ^ d[i]);
    end
    q_m[8] = !xnor_form;
    bal = 2 * count_ones({2'b00, q_m[7:0]}, 8) - 8;
    if ((disp == 0) || (bal == 0)) begin
        return {!q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
    end else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0))) begin
        return {1'b1, q_m[8], ~q_m[7:0]};
    end
    return {1'b0, q_m[8], q_m[7:0]};
endfunction

// control period symbol for {c1, c0}
function automatic video_pkg::tmds_word_t control_symbol(bit c1, bit c0);
    case ({c1, c0})
        2'b00:   return video_pkg::tmds_ctrl_00;
        2'b01:   return video_pkg::tmds_ctrl_01;
        2'b10:   return video_pkg::tmds_ctrl_10;
        default: return video_pkg::tmds_ctrl_11;
    endcase
endfunction

// lane 0 blue, lane 1 green, lane 2 red
function automatic video_pkg::color_t pattern_color(int lane, int x, int y, bit bars,
                                                    int active_width);
    int bar;
    int value;
    bar = x / (active_width / 8);
    if (bars) begin
        // bar bit 0 lights red, bit 1 green, bit 2 blue
        value = bar[2 - lane] ? 255 : 0;
    end else if (lane == 2) begin
        value = x;
    end else if (lane == 1) begin
        value = y;
    end else begin
        value = x + y;
    end
    return video_pkg::color_t'(value & 255);
endfunction

// position inside [start, start + len)
function automatic bit in_window(int pos, int start, int len);
    return (pos >= start) && (pos < start + len);
endfunction

`endif

//--- sim/tb_vga_dvi.sv
`timescale 1ns/100ps

module tb_vga_dvi;

    `include "tmds_model.svh"

    // small raster so a frame is short
    localparam int h_active = 32;
    localparam int h_front  = 4;
    localparam int h_sync   = 6;
    localparam int h_back   = 24;
    localparam int v_active = 6;
    localparam int v_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 3;

    localparam int h_total      = h_active + h_front + h_sync + h_back;
    localparam int v_total      = v_active + v_front + v_sync + v_back;
    localparam int frame_cycles = h_total * v_total;
    localparam int frames       = 4;
    localparam int latency      = 3;
    // reset, all frames and pipeline drain, stretched by 1.5 at 8 ns each
    localparam int run_cycles   = 4 + frames * frame_cycles + latency + 4;
    localparam int watchdog_ns  = run_cycles * 12;

    logic                  clk_pixel;
    logic                  reset;
    logic                  test_picture;
    video_pkg::tmds_word_t tmds_red;
    video_pkg::tmds_word_t tmds_green;
    video_pkg::tmds_word_t tmds_blue;

    integer      seed = 32'hc3cd;
    logic [31:0] draw;
    bit          running;
    int          checked_cycles;

    // model raster and pipeline history
    int    model_x;
    int    model_y;
    int    hist_x[$];
    int    hist_y[$];
    bit    hist_tp[$];
    int    disparity [3];
    string lane_name [3] = '{"tmds_blue", "tmds_green", "tmds_red"};

    vga_dvi_top #(
        .h_active (h_active),
        .h_front  (h_front),
        .h_sync   (h_sync),
        .h_back   (h_back),
        .v_active (v_active),
        .v_front  (v_front),
        .v_sync   (v_sync),
        .v_back   (v_back)
    ) dut (
        .clk_pixel    (clk_pixel),
        .reset        (reset),
        .test_picture (test_picture),
        .tmds_red     (tmds_red),
        .tmds_green   (tmds_green),
        .tmds_blue    (tmds_blue)
    );

    always #4 clk_pixel = ~clk_pixel;

    task automatic check_value(string name, logic [9:0] expected, logic [9:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // compare all lanes against the pixel at (px, py)
    task automatic check_pixel(int px, int py, bit bars);
        bit                    blanked;
        bit                    hs;
        bit                    vs;
        bit                    bounded;
        video_pkg::tmds_word_t expected;
        video_pkg::tmds_word_t actual [3];
        actual[0] = tmds_blue;
        actual[1] = tmds_green;
        actual[2] = tmds_red;
        blanked = (px >= h_active) || (py >= v_active);
        hs = in_window(px, h_active + h_front, h_sync);
        vs = in_window(py, v_active + v_front, v_sync);
        for (int lane = 0; lane < 3; lane++) begin
            if (blanked) begin
                expected = (lane == 0) ? control_symbol(vs, hs) : video_pkg::tmds_ctrl_00;
                disparity[lane] = 0;
                check_value(lane_name[lane], expected, actual[lane]);
            end else begin
                expected = encode_pixel(pattern_color(lane, px, py, bars, h_active),
                                        disparity[lane]);
                check_value(lane_name[lane], expected, actual[lane]);
                // running DC offset of the verified symbol stream
                disparity[lane] = disparity[lane] + symbol_balance(expected);
                bounded = (disparity[lane] >= -10) && (disparity[lane] <= 10);
                check_value({lane_name[lane], " disparity in range"}, 10'd1, 10'(bounded));
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk_pixel) begin
        if (running) begin
            hist_x.push_back(model_x);
            hist_y.push_back(model_y);
            hist_tp.push_back(test_picture);
            if (hist_x.size() > latency) begin
                check_pixel(hist_x.pop_front(), hist_y.pop_front(), hist_tp.pop_front());
            end else begin
                // pipeline still holds reset state
                check_value("tmds_blue", video_pkg::tmds_ctrl_00, tmds_blue);
                check_value("tmds_green", video_pkg::tmds_ctrl_00, tmds_green);
                check_value("tmds_red", video_pkg::tmds_ctrl_00, tmds_red);
            end
            if (model_x == h_total - 1) begin
                model_x = 0;
                model_y = (model_y == v_total - 1) ? 0 : model_y + 1;
            end else begin
                model_x = model_x + 1;
            end
            checked_cycles = checked_cycles + 1;
        end
    end

    initial begin
        clk_pixel      = 1'b0;
        reset          = 1'b1;
        test_picture   = 1'b0;
        running        = 1'b0;
        checked_cycles = 0;
        model_x        = 0;
        model_y        = 0;
        disparity      = '{0, 0, 0};
        repeat (4) @(posedge clk_pixel);
        #1;
        reset   = 1'b0;
        running = 1'b1;
        // new picture at the first pixel of each frame
        for (int frame = 0; frame < frames; frame++) begin
            draw = $random(seed);
            if (frame == 1) begin
                test_picture = !test_picture;
            end else begin
                test_picture = draw[0];
            end
            repeat (frame_cycles) @(posedge clk_pixel);
            #1;
        end
        repeat (latency) @(posedge clk_pixel);
        #1;
        if (checked_cycles != frames * frame_cycles + latency) begin
            $display("only %0d of %0d output cycles were compared", checked_cycles,
                     frames * frame_cycles + latency);
            $display("Simulation FAILED");
            $fatal(1, "compare process fell behind");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the frames did not complete within %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- filelist.f
+incdir+sim
common/video_pkg.sv
design/video_timing.sv
design/test_pattern.sv
tmds/tmds_encoder.sv
tmds/dvi_transmitter.sv
design/vga_dvi_top.sv
sim/tb_vga_dvi.sv
